/* common/cart_pkg.sv */
// Types for the cartridge mapping side
// Shared by the bank registers, the address translator and the top level
// Import inside a module body, use cart_pkg:: names in port lists

package cart_pkg;

	//////////////////////////////////////////////////
	// Address and bank types
	//////////////////////////////////////////////////

	typedef logic [23:1]  cpu_word_addr_t;  // CPU word address, byte bit dropped
	typedef logic [4:0]   bank_t;           // One 512 KB bank number
	typedef logic [2:0]   bank_sel_t;       // Bank register index
	typedef logic [23:13] rom_mask_t;       // Size mask in 8 KB steps
	typedef logic [23:0]  mem_word_addr_t;  // Memory side word address

	localparam int NUM_BANKS = 8;

	// Reset value of each bank register is its own index,
	// which gives a flat mapping of the first 4 MB
	typedef bank_t [NUM_BANKS-1:0] bank_array_t;

	//////////////////////////////////////////////////
	// CPU bus as seen by the mapper
	//////////////////////////////////////////////////

	typedef struct packed {
		cpu_word_addr_t va;         // Word address
		logic [15:0]    vdo;        // Write data from the CPU
		logic           rnw;        // High on reads
		logic           page_ce_n;  // Page register window select, active low
	} cpu_bus_t;

endpackage

/* common/host_pkg.sv */
// Types and constants for the host side of the core
// Download bus, keyboard events and the console region
// Import inside a module body, use host_pkg:: names in port lists

package host_pkg;

	//////////////////////////////////////////////////
	// Host download bus, 16 bit wide
	//////////////////////////////////////////////////

	typedef struct packed {
		logic        download;  // High for the whole transfer
		logic [7:0]  index;     // File type, bit 6 marks a cartridge
		logic        wr;        // One strobe per word
		logic [24:0] addr;      // Byte address of the word
		logic [15:0] data;      // Word, low byte first in the file
	} dl_bus_t;

	// Keyboard event, toggle flips on each new event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} key_evt_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	//////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////

	localparam logic [5:0] ROM_INDEX_MAX  = 6'd1;  // Index 0 and 1 load ROM images
	localparam int         CART_INDEX_BIT = 6;

	// Scan codes of the region hot keys
	localparam logic [8:0] KEY_F1 = 9'h005;
	localparam logic [8:0] KEY_F2 = 9'h006;
	localparam logic [8:0] KEY_F3 = 9'h004;

	// Region letters in the cartridge header
	localparam logic [7:0] HDR_CHAR_US = "U";
	localparam logic [7:0] HDR_CHAR_JP = "J";

endpackage

/* design/loader/load_decoder.sv */
// Download classifier for ROM and BIOS images
// Gives the ROM loading level and write strobe, the cart mode of the
// current download and the ROM size mask built from the loaded addresses

module load_decoder (
	input  logic                clk_sys,
	input  logic                reset,
	input  host_pkg::dl_bus_t   dl,
	output logic                rom_loading,
	output logic                load_wr,
	output logic                cart_mode,
	output cart_pkg::rom_mask_t rom_mask
);

	import host_pkg::*;

	logic index_is_rom;
	logic index_is_cart;
	logic addr_zero;

	//////////////////////////////////////////////////
	// Index decode
	//////////////////////////////////////////////////

	assign index_is_rom  = (dl.index[5:0] <= ROM_INDEX_MAX);
	assign index_is_cart = dl.index[CART_INDEX_BIT];
	assign addr_zero     = (dl.addr == '0);

	assign rom_loading = dl.download & index_is_rom;
	assign load_wr     = rom_loading & dl.wr;  // One strobe per ROM word

	//////////////////////////////////////////////////
	// Size mask and cart mode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask  <= '0;
			cart_mode <= 1'b0;
		end else if (load_wr) begin
			cart_mode <= index_is_cart;

			// First word of a new image starts a fresh mask
			if (addr_zero) begin
				rom_mask <= '0;
			end else if (index_is_cart) begin
				rom_mask <= rom_mask | dl.addr[23:13];  // Highest address wins
			end
		end
	end

endmodule

/* design/loader/header_sniffer.sv */
// Cartridge header region detector
// Picks the region letter out of the ROM image while it is loaded
// and flags it ready until the next start or end of a ROM download

module header_sniffer #(
	parameter logic [24:0] REGION_ADDR = 25'h1F0
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  host_pkg::dl_bus_t dl,
	input  logic              rom_loading,
	output logic              hdr_ready,
	output host_pkg::region_t hdr_region
);

	import host_pkg::*;

	logic    loading_q;
	logic    loading_edge;
	logic    hdr_wr;
	region_t letter_region;

	assign loading_edge = loading_q ^ rom_loading;  // Start or end of a download
	assign hdr_wr       = rom_loading & dl.wr & (dl.addr == REGION_ADDR);

	// Region letter sits in the low byte of the word
	always_comb begin
		case (dl.data[7:0])
			HDR_CHAR_US: letter_region = REGION_US;
			HDR_CHAR_JP: letter_region = REGION_JP;
			default:     letter_region = REGION_EU;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loading_q <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			loading_q <= rom_loading;
			if (loading_edge) hdr_ready <= 1'b0;
			if (hdr_wr) hdr_ready <= 1'b1;  // Header write wins over the edge
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) hdr_region <= letter_region;
	end

endmodule

/* design/region_select.sv */
// Region request to the host
// Header detection sets the region once per ROM, F1 to F3 override it
// region_set is a level the host uses to apply the request

module region_select (
	input  logic               clk_sys,
	input  logic               reset,
	input  host_pkg::key_evt_t key,
	input  logic               hdr_ready,
	input  host_pkg::region_t  hdr_region,
	output host_pkg::region_t  region_req,
	output logic               region_set
);

	import host_pkg::*;

	logic toggle_q;
	logic ready_q;
	logic key_seen;
	logic hdr_rise;
	logic hdr_fall;

	assign key_seen = toggle_q ^ key.toggle;
	assign hdr_rise = hdr_ready & ~ready_q;
	assign hdr_fall = ~hdr_ready & ready_q;

	always_ff @(posedge clk_sys) begin
		// Previous levels for the edge detect
		toggle_q <= key.toggle;
		ready_q  <= hdr_ready;

		if (reset) begin
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			if (key_seen) begin
				case (key.code)
					KEY_F1: begin
						region_req <= REGION_JP;
						region_set <= key.pressed;
					end
					KEY_F2: begin
						region_req <= REGION_US;
						region_set <= key.pressed;
					end
					KEY_F3: begin
						region_req <= REGION_EU;
						region_set <= key.pressed;
					end
					default: ;
				endcase
			end

			// Header comes last so it takes priority over a key
			if (hdr_rise) begin
				region_req <= hdr_region;
				region_set <= 1'b1;
			end
			if (hdr_fall) region_set <= 1'b0;
		end
	end

endmodule

/* design/mapper/bank_regs.sv */
// Bank registers for ROMs above 4 MB
// Written by the CPU through the page register window, one register per
// word at va[3:1], back to the flat mapping on reset and while loading

module bank_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::cpu_bus_t    cpu,
	input  logic                  rom_loading,
	input  cart_pkg::rom_mask_t   rom_mask,
	output cart_pkg::bank_array_t banks
);

	import cart_pkg::*;

	logic      page_ce_q;
	logic      page_fall;
	logic      big_rom;
	bank_sel_t sel;
	logic      bank_wr;

	assign sel       = cpu.va[3:1];
	assign page_fall = page_ce_q & ~cpu.page_ce_n;
	assign big_rom   = |rom_mask[23:22];  // Image reaches past 4 MB

	// Register 0 stays fixed, reads never write
	assign bank_wr = page_fall & ~cpu.rnw & (sel != '0) & big_rom;

	//////////////////////////////////////////////////
	// Window edge detect
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_ce_q <= 1'b1;
		end else begin
			page_ce_q <= cpu.page_ce_n;
		end
	end

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || rom_loading) begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				banks[i] <= bank_t'(i);  // Identity mapping
			end
		end else if (bank_wr) begin
			banks[sel] <= cpu.vdo[4:0];
		end
	end

endmodule

/* design/mapper/rom_addr_map.sv */
// Memory address and write path for the ROM area
// Load writes go straight to memory, CPU reads go through the banks and mask
// Purely combinational

module rom_addr_map #(
	parameter logic [5:0] BIOS_PREFIX = 6'b011110
) (
	input  logic                     rom_loading,
	input  logic                     load_wr,
	input  logic                     cart_mode,
	input  host_pkg::dl_bus_t        dl,
	input  cart_pkg::cpu_bus_t       cpu,
	input  cart_pkg::bank_array_t    banks,
	input  cart_pkg::rom_mask_t      rom_mask,
	output cart_pkg::mem_word_addr_t mem_addr,
	output logic [15:0]              mem_data,
	output logic                     mem_wr
);

	import cart_pkg::*;

	cpu_word_addr_t rom_va;

	// Bank picks the 512 KB block, mask folds small ROMs
	assign rom_va = {banks[cpu.va[21:19]], cpu.va[18:1]} & {rom_mask, 12'hFFF};

	assign mem_data = {dl.data[7:0], dl.data[15:8]};  // File is little endian

	always_comb begin
		if (rom_loading) begin
			if (cart_mode) begin
				mem_addr = {2'b00, dl.addr[22:1]};
			end else begin
				mem_addr = {BIOS_PREFIX, dl.addr[18:1]};  // BIOS area
			end
			mem_wr = load_wr;
		end else begin
			mem_addr = {2'b00, rom_va[22:1]};
			mem_wr   = 1'b0;  // ROM is read only for the CPU
		end
	end

endmodule

/* design/cart_map_top.sv */
// Cartridge loading and ROM mapping path of the console core
// Host downloads in, memory writes and CPU address translation out,
// plus the region request raised from the cartridge header or F1 to F3

module cart_map_top #(
	parameter logic [24:0] REGION_ADDR = 25'h1F0,
	parameter logic [5:0]  BIOS_PREFIX = 6'b011110
) (
	input  logic                     clk_sys,
	input  logic                     reset,

	input  host_pkg::dl_bus_t        dl,
	input  host_pkg::key_evt_t       key,
	input  cart_pkg::cpu_bus_t       cpu,

	output cart_pkg::mem_word_addr_t mem_addr,
	output logic [15:0]              mem_data,
	output logic                     mem_wr,
	output logic                     rom_loading,
	output host_pkg::region_t        region_req,
	output logic                     region_set
);

	import cart_pkg::*;
	import host_pkg::*;

	logic        load_wr;
	logic        cart_mode;
	rom_mask_t   rom_mask;
	logic        hdr_ready;
	region_t     hdr_region;
	bank_array_t banks;

	//////////////////////////////////////////////////
	// Loader
	//////////////////////////////////////////////////

	load_decoder u_load_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.rom_loading (rom_loading),
		.load_wr     (load_wr),
		.cart_mode   (cart_mode),
		.rom_mask    (rom_mask)
	);

	header_sniffer #(
		.REGION_ADDR (REGION_ADDR)
	) u_header_sniffer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.rom_loading (rom_loading),
		.hdr_ready   (hdr_ready),
		.hdr_region  (hdr_region)
	);

	region_select u_region_select (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.key        (key),
		.hdr_ready  (hdr_ready),
		.hdr_region (hdr_region),
		.region_req (region_req),
		.region_set (region_set)
	);

	//////////////////////////////////////////////////
	// Mapper
	//////////////////////////////////////////////////

	bank_regs u_bank_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu         (cpu),
		.rom_loading (rom_loading),
		.rom_mask    (rom_mask),
		.banks       (banks)
	);

	rom_addr_map #(
		.BIOS_PREFIX (BIOS_PREFIX)
	) u_rom_addr_map (
		.rom_loading (rom_loading),
		.load_wr     (load_wr),
		.cart_mode   (cart_mode),
		.dl          (dl),
		.cpu         (cpu),
		.banks       (banks),
		.rom_mask    (rom_mask),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.mem_wr      (mem_wr)
	);

endmodule

/* verif/tb_cart_map.sv */
// Testbench for the cartridge loading and ROM mapping path
// Drives host downloads, key events and CPU page writes into cart_map_top
// and checks memory writes, region requests and bank translation

module tb_cart_map;

	import cart_pkg::*;
	import host_pkg::*;

	localparam int          CLK_PERIOD   = 4;
	localparam int          RESET_CYCLES = 3;
	localparam logic [24:0] HDR_ADDR     = 25'h1F0;
	localparam logic [5:0]  BIOS_PFX     = 6'b011110;

	// Cycle budget of each test
	localparam int LOAD_CYCLES   = 30;
	localparam int MASK_CYCLES   = 30;
	localparam int HDR_CYCLES    = 40;
	localparam int KEY_CYCLES    = 15;
	localparam int BANK_CYCLES   = 80;
	localparam int RUN_CYCLES    = RESET_CYCLES + LOAD_CYCLES + MASK_CYCLES + HDR_CYCLES
		+ KEY_CYCLES + BANK_CYCLES;
	localparam int WATCHDOG_TIME = RUN_CYCLES * CLK_PERIOD * 2;

	logic           clk_sys = 1'b0;
	logic           reset;
	dl_bus_t        dl;
	key_evt_t       key;
	cpu_bus_t       cpu;
	mem_word_addr_t mem_addr;
	logic [15:0]    mem_data;
	logic           mem_wr;
	logic           rom_loading;
	region_t        region_req;
	logic           region_set;

	// Reference model state
	rom_mask_t m_mask;
	logic      m_cart;
	bank_t     m_banks [NUM_BANKS];
	region_t   m_region;
	logic      m_set;
	logic      exp_mem_wr;  // ROM index with a write strobe

	string test_name;
	int    errors;
	int    test_errors;
	int    checks;
	int    tests;

	cart_map_top #(
		.REGION_ADDR (HDR_ADDR),
		.BIOS_PREFIX (BIOS_PFX)
	) DUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.key         (key),
		.cpu         (cpu),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.mem_wr      (mem_wr),
		.rom_loading (rom_loading),
		.region_req  (region_req),
		.region_set  (region_set)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	assign exp_mem_wr = dl.download && (dl.index[5:0] <= ROM_INDEX_MAX) && dl.wr;

	// Memory writes only come from ROM load strobes
	assert property (@(posedge clk_sys) disable iff (reset) mem_wr == exp_mem_wr)
	else begin
		$display("[ERROR] %s: mem_wr expected %b actual %b", test_name,
			exp_mem_wr, mem_wr);
		errors++;
		test_errors++;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic tick();
		@(posedge clk_sys);
		#1;  // Drive point after the edge
	endtask

	task automatic settle();
		#1;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests++;
		$display("test %-14s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "FAILED",
			test_errors);
	endtask

	task automatic identity_banks();
		for (int i = 0; i < NUM_BANKS; i++) begin
			m_banks[i] = bank_t'(i);
		end
	endtask

	function automatic mem_word_addr_t load_addr(input logic cart, input logic [24:0] addr);
		if (cart) return {2'b00, addr[22:1]};
		return {BIOS_PFX, addr[18:1]};  // BIOS area
	endfunction

	// Bank picks the 512 KB block, then the size mask folds it
	function automatic mem_word_addr_t cpu_addr(input cpu_word_addr_t va);
		logic [23:1] phys;
		phys = {m_banks[va[21:19]], va[18:1]};
		phys = phys & {m_mask, 12'hFFF};
		return {2'b00, phys[22:1]};
	endfunction

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic start_download(input logic [7:0] index);
		logic is_rom;
		tick();
		dl.download = 1'b1;
		dl.index    = index;
		dl.wr       = 1'b0;
		settle();
		is_rom = (index[5:0] <= ROM_INDEX_MAX);
		check_eq("rom_loading", 32'(is_rom), 32'(rom_loading));
		if (is_rom) identity_banks();  // Banks reload while loading
	endtask

	task automatic end_download();
		tick();
		dl.download = 1'b0;
		dl.wr       = 1'b0;
		settle();
	endtask

	task automatic load_word(input logic [24:0] addr, input logic [15:0] data);
		logic is_rom;
		tick();
		dl.wr   = 1'b1;
		dl.addr = addr;
		dl.data = data;
		settle();
		is_rom = dl.download && (dl.index[5:0] <= ROM_INDEX_MAX);
		check_eq("rom_loading", 32'(is_rom), 32'(rom_loading));
		if (is_rom) begin
			check_eq("mem_addr", 32'(load_addr(m_cart, addr)), 32'(mem_addr));
			check_eq("mem_data", 32'({data[7:0], data[15:8]}), 32'(mem_data));
			check_eq("mem_wr", 32'd1, 32'(mem_wr));
			// State taken at the next edge
			m_cart = dl.index[CART_INDEX_BIT];
			if (addr == '0) begin
				m_mask = '0;
			end else if (dl.index[CART_INDEX_BIT]) begin
				m_mask = m_mask | addr[23:13];
			end
		end else begin
			check_eq("mem_wr", 32'd0, 32'(mem_wr));
		end
		tick();
		dl.wr = 1'b0;
		settle();
	endtask

	task automatic map_check(input cpu_word_addr_t va);
		tick();
		cpu.va        = va;
		cpu.rnw       = 1'b1;
		cpu.page_ce_n = 1'b1;
		settle();
		check_eq("cpu mem_addr", 32'(cpu_addr(va)), 32'(mem_addr));
		check_eq("cpu mem_wr", 32'd0, 32'(mem_wr));
	endtask

	task automatic map_bank(input bank_sel_t sel);
		cpu_word_addr_t va;
		va        = cpu_word_addr_t'($urandom);
		va[21:19] = sel;
		map_check(va);
	endtask

	task automatic page_write(input bank_sel_t sel, input bank_t value, input logic rnw);
		tick();
		cpu.va        = cpu_word_addr_t'($urandom);
		cpu.va[3:1]   = sel;
		cpu.vdo       = 16'($urandom);
		cpu.vdo[4:0]  = value;
		cpu.rnw       = rnw;
		cpu.page_ce_n = 1'b0;  // Falling edge of the window
		settle();
		if (!rnw && sel != '0 && m_mask[23:22] != '0) m_banks[sel] = value;
		tick();
		cpu.page_ce_n = 1'b1;
		settle();
	endtask

	task automatic key_event(input logic [8:0] code, input logic pressed);
		tick();
		key.toggle  = ~key.toggle;
		key.code    = code;
		key.pressed = pressed;
		settle();
		case (code)
			KEY_F1: begin
				m_region = REGION_JP;
				m_set    = pressed;
			end
			KEY_F2: begin
				m_region = REGION_US;
				m_set    = pressed;
			end
			KEY_F3: begin
				m_region = REGION_EU;
				m_set    = pressed;
			end
			default: ;
		endcase
		tick();
		check_eq("key region_req", 32'(m_region), 32'(region_req));
		check_eq("key region_set", 32'(m_set), 32'(region_set));
	endtask

	task automatic hdr_download(input logic [7:0] letter, input region_t exp);
		start_download(8'h40);
		load_word('0, 16'($urandom));
		load_word(HDR_ADDR, {8'h20, letter});  // Letter in the low byte
		check_eq("region_set early", 32'd0, 32'(region_set));
		tick();
		check_eq("region_set", 32'd1, 32'(region_set));
		check_eq("region_req", 32'(exp), 32'(region_req));
		end_download();
		tick();
		check_eq("region_set held", 32'd1, 32'(region_set));
		tick();
		check_eq("region_set cleared", 32'd0, 32'(region_set));
		m_region = exp;
		m_set    = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_load_writes();
		begin_test("load_writes");
		start_download(8'h40);
		load_word('0, 16'h1234);  // Sets cart mode for the later words
		load_word(25'h12_3456, 16'($urandom));
		load_word(25'h7F_FFFE, 16'($urandom));
		end_download();
		start_download(8'h01);
		load_word('0, 16'hA55A);
		load_word(25'h01_2344, 16'($urandom));
		load_word(25'h07_FFFE, 16'($urandom));
		end_download();
		start_download(8'h02);    // Not a ROM index
		load_word(25'h100, 16'($urandom));
		end_download();
		start_download(8'h43);
		load_word(25'h200, 16'($urandom));
		end_download();
		end_test();
	endtask

	task automatic test_mask_map();
		logic [24:0] top;
		logic [24:0] mid;
		begin_test("mask_map");
		repeat (4) map_check(cpu_word_addr_t'($urandom));
		top = (25'($urandom) & 25'hFF_FFFE) | 25'h2000;
		mid = (25'($urandom) & 25'h3F_FFFE) | 25'h2000;
		start_download(8'h40);
		load_word('0, 16'($urandom));
		load_word(mid, 16'($urandom));
		load_word(top, 16'($urandom));
		end_download();
		repeat (6) map_check(cpu_word_addr_t'($urandom));
		end_test();
	endtask

	task automatic test_region_header();
		begin_test("region_header");
		hdr_download("U", REGION_US);
		hdr_download("J", REGION_JP);
		hdr_download("E", REGION_EU);
		end_test();
	endtask

	task automatic test_key_region();
		begin_test("key_region");
		key_event(KEY_F2, 1'b1);
		key_event(KEY_F1, 1'b1);
		key_event(KEY_F3, 1'b0);
		key_event(9'h01C, 1'b1);  // Other keys leave the region alone
		key_event(KEY_F2, 1'b0);
		end_test();
	endtask

	task automatic test_bank_window();
		logic [24:0] top;
		begin_test("bank_window");
		top = (25'($urandom) & 25'hFF_FFFE) | 25'h78_0000;  // Past 4 MB
		start_download(8'h40);
		load_word('0, 16'($urandom));
		load_word(top, 16'($urandom));
		end_download();
		for (int i = 1; i < NUM_BANKS; i++) begin
			page_write(bank_sel_t'(i), bank_t'($urandom), 1'b0);
			map_bank(bank_sel_t'(i));
		end
		page_write(3'd0, bank_t'($urandom), 1'b0);
		map_bank(3'd0);
		page_write(3'd3, bank_t'($urandom), 1'b1);
		map_bank(3'd3);

		// Small ROM keeps the identity mapping
		top = (25'($urandom) & 25'h3F_FFFE) | 25'h38_0000;
		start_download(8'h40);
		load_word('0, 16'($urandom));
		load_word(top, 16'($urandom));
		end_download();
		for (int i = 1; i < NUM_BANKS; i++) begin
			page_write(bank_sel_t'(i), bank_t'($urandom), 1'b0);
			map_bank(bank_sel_t'(i));
		end
		end_test();
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(51));
		errors        = 0;
		test_errors   = 0;
		checks        = 0;
		tests         = 0;
		test_name     = "reset";
		reset         = 1'b1;
		dl            = '0;
		key           = '0;
		cpu           = '0;
		cpu.rnw       = 1'b1;
		cpu.page_ce_n = 1'b1;
		m_mask        = '0;
		m_cart        = 1'b0;
		m_region      = REGION_JP;
		m_set         = 1'b0;
		identity_banks();
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		test_load_writes();
		test_mask_map();
		test_region_header();
		test_key_region();
		test_bank_window();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: tests did not finish within %0d time units", WATCHDOG_TIME);
		$display("sim failed");
		$finish;
	end

endmodule

/* vlog.f */
common/cart_pkg.sv
common/host_pkg.sv
design/loader/load_decoder.sv
design/loader/header_sniffer.sv
design/region_select.sv
design/mapper/bank_regs.sv
design/mapper/rom_addr_map.sv
design/cart_map_top.sv
verif/tb_cart_map.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the cartridge mapping testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_cart_map \
	--Mdir obj_dir -o tb_cart_map > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_cart_map > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
	exit 1
fi
exit 0
